// ==== logic/io_defs.svh ====
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// Hardware threads sharing the I/O path
`define THREADS_PER_CORE 4
`define THREAD_IDX_WIDTH 2

// Scratch register window
`define IO_NUM_REGS 8
`define IO_REG_IDX_WIDTH 3

// Word address of register 0
`define IO_REG_BASE 32'h0000_0100

// Data and address word
`define SCALAR_WIDTH 32

`endif

// ==== logic/io_pkg.sv ====
`default_nettype none

`include "io_defs.svh"

package io_pkg;

  typedef logic [`SCALAR_WIDTH-1:0] scalar_t;

  typedef logic [`THREAD_IDX_WIDTH-1:0] local_thread_idx_t;

  // One bit per hardware thread
  typedef logic [`THREADS_PER_CORE-1:0] local_thread_bitmap_t;

  // Request from the queue to the interconnect
  typedef struct packed
  {
    logic store;
    scalar_t address;
    scalar_t value;
    local_thread_idx_t thread_idx;
  } ioreq_packet_t;

  // Response back to the queue, tagged with the issuing thread
  typedef struct packed
  {
    local_thread_idx_t thread_idx;
    scalar_t read_value;
  } iorsp_packet_t;

endpackage

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter
  #(parameter NUM_REQUESTERS = 4)
  (
    input logic clk,
    input logic reset,
    input logic [NUM_REQUESTERS-1:0] request,
    input logic update_lru,
    output logic [NUM_REQUESTERS-1:0] grant_oh
  );

  localparam IDX_WIDTH = NUM_REQUESTERS > 1 ? $clog2(NUM_REQUESTERS) : 1;

  logic [IDX_WIDTH-1:0] last_winner;

  // Search starts just past the last winner
  always_comb
  begin
    int candidate;
    grant_oh = '0;
    for (int i = 1; i <= NUM_REQUESTERS; i++)
    begin
      candidate = (int'(last_winner) + i) % NUM_REQUESTERS;
      if (grant_oh == '0 && request[candidate])
        grant_oh[candidate] = 1'b1;
    end
  end

  // Priority rotates only when the grant is actually used
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      last_winner <= IDX_WIDTH'(NUM_REQUESTERS - 1);
    else if (update_lru && |grant_oh)
    begin
      for (int i = 0; i < NUM_REQUESTERS; i++)
      begin
        if (grant_oh[i])
          last_winner <= IDX_WIDTH'(i);
      end
    end
  end

  grant_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant_oh));

  // No requester may be left waiting while the arbiter idles
  grant_when_requested: assert property (@(posedge clk) disable iff (reset)
    |request |-> |grant_oh);

endmodule

`default_nettype wire

// ==== logic/io_request_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_defs.svh"

module io_request_queue
  import io_pkg::*;
  (
    input logic clk,
    input logic reset,

    // Access strobes from the data cache stage
    input logic dd_io_write_en,
    input logic dd_io_read_en,
    input local_thread_idx_t dd_io_thread_idx,
    input scalar_t dd_io_adr,
    input scalar_t dd_io_write_value,

    // To writeback and thread scheduling
    output scalar_t ior_read_value,
    output logic ior_rollback_en,
    output local_thread_bitmap_t ior_pending,
    output local_thread_bitmap_t ior_wake_bitmap,

    // Interconnect side
    input logic ii_ready,
    input logic ii_response_valid,
    input iorsp_packet_t ii_response,
    output logic ior_request_valid,
    output ioreq_packet_t ior_request
  );

  typedef struct packed
  {
    logic store;
    scalar_t address;
    scalar_t value;
  } io_slot_t;

  io_slot_t slot_data[`THREADS_PER_CORE];
  local_thread_bitmap_t slot_valid;
  local_thread_bitmap_t slot_sent;
  local_thread_bitmap_t in_flight;
  local_thread_bitmap_t send_request;
  local_thread_bitmap_t send_grant_oh;
  local_thread_idx_t send_grant_idx;
  logic issue_en;
  logic transfer_en;

  assign issue_en = dd_io_write_en || dd_io_read_en;
  assign transfer_en = ior_request_valid && ii_ready;

  genvar t;
  generate
    for (t = 0; t < `THREADS_PER_CORE; t++)
    begin : slot_gen
      logic issue_hit;
      logic response_hit;
      logic grant_hit;

      assign issue_hit = issue_en && dd_io_thread_idx == local_thread_idx_t'(t);
      assign response_hit = ii_response_valid
        && ii_response.thread_idx == local_thread_idx_t'(t);
      assign grant_hit = transfer_en && send_grant_idx == local_thread_idx_t'(t);

      assign send_request[t] = slot_valid[t] && !slot_sent[t];
      assign ior_pending[t] = (slot_valid[t] && slot_sent[t]) || send_grant_oh[t];

      // First issue opens the slot, the re-issue closes it
      always_ff @(posedge clk or posedge reset)
      begin
        if (reset)
        begin
          slot_valid[t] <= 1'b0;
          slot_sent[t] <= 1'b0;
          in_flight[t] <= 1'b0;
        end
        else
        begin
          if (issue_hit)
          begin
            slot_valid[t] <= !slot_valid[t];
            slot_sent[t] <= 1'b0;
          end
          else if (grant_hit)
            slot_sent[t] <= 1'b1;

          if (grant_hit)
            in_flight[t] <= 1'b1;
          else if (response_hit)
            in_flight[t] <= 1'b0;
        end
      end

      always_ff @(posedge clk)
      begin
        if (issue_hit && !slot_valid[t])
          slot_data[t] <= '{store: dd_io_write_en, address: dd_io_adr,
            value: dd_io_write_value};
        else if (response_hit)
          slot_data[t].value <= ii_response.read_value;
      end

      response_to_valid_slot: assert property (@(posedge clk) disable iff (reset)
        response_hit |-> slot_valid[t]);

      // Thread stays blocked until its response has come back
      no_issue_while_in_flight: assert property (@(posedge clk) disable iff (reset)
        issue_hit |-> !in_flight[t]);
    end
  endgenerate

  rr_arbiter #(.NUM_REQUESTERS(`THREADS_PER_CORE)) i_request_arbiter
  (
    .clk(clk),
    .reset(reset),
    .request(send_request),
    .update_lru(transfer_en),
    .grant_oh(send_grant_oh)
  );

  always_comb
  begin
    send_grant_idx = '0;
    for (int i = 0; i < `THREADS_PER_CORE; i++)
    begin
      if (send_grant_oh[i])
        send_grant_idx = local_thread_idx_t'(i);
    end
  end

  assign ior_request_valid = |send_request;
  assign ior_request = '{store: slot_data[send_grant_idx].store,
    address: slot_data[send_grant_idx].address,
    value: slot_data[send_grant_idx].value,
    thread_idx: send_grant_idx};

  // Wake the thread whose response is on the bus this cycle
  assign ior_wake_bitmap = ii_response_valid
    ? local_thread_bitmap_t'(1) << ii_response.thread_idx
    : local_thread_bitmap_t'(0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ior_rollback_en <= 1'b0;
    else
      ior_rollback_en <= issue_en && !slot_valid[dd_io_thread_idx];
  end

  always_ff @(posedge clk)
    ior_read_value <= slot_data[dd_io_thread_idx].value;

endmodule

`default_nettype wire

// ==== logic/io_interconnect.sv ====
`timescale 1ns/1ns
`default_nettype none

module io_interconnect
  import io_pkg::*;
  (
    input logic clk,
    input logic reset,

    // Request and response channels to the queue
    input logic ior_request_valid,
    input ioreq_packet_t ior_request,
    output logic ii_ready,
    output logic ii_response_valid,
    output iorsp_packet_t ii_response,

    // Register bank port
    output logic bank_access_en,
    output logic bank_store,
    output scalar_t bank_adr,
    output scalar_t bank_write_value,
    input scalar_t bank_read_value
  );

  typedef enum logic [1:0]
  {
    IC_IDLE,
    IC_ACCESS,
    IC_RESPOND
  } ic_state_t;

  ic_state_t state;
  ioreq_packet_t active_request;
  scalar_t response_value;

  // One request in flight at a time
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= IC_IDLE;
    else
    begin
      case (state)
        IC_IDLE:
          if (ior_request_valid)
            state <= IC_ACCESS;
        IC_ACCESS:
          state <= IC_RESPOND;
        default:
          state <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IC_IDLE && ior_request_valid)
      active_request <= ior_request;

    // Stores echo the written value
    if (state == IC_ACCESS)
      response_value <= active_request.store ? active_request.value : bank_read_value;
  end

  assign ii_ready = state == IC_IDLE;

  assign bank_access_en = state == IC_ACCESS;
  assign bank_store = state == IC_ACCESS && active_request.store;
  assign bank_adr = active_request.address;
  assign bank_write_value = active_request.value;

  assign ii_response_valid = state == IC_RESPOND;
  assign ii_response = '{thread_idx: active_request.thread_idx, read_value: response_value};

  single_cycle_response: assert property (@(posedge clk) disable iff (reset)
    ii_response_valid |=> !ii_response_valid);

endmodule

`default_nettype wire

// ==== logic/io_register_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_defs.svh"

module io_register_bank
  import io_pkg::*;
  (
    input logic clk,
    input logic reset,
    input logic bank_access_en,
    input logic bank_store,
    input scalar_t bank_adr,
    input scalar_t bank_write_value,
    output scalar_t bank_read_value
  );

  scalar_t regs[`IO_NUM_REGS];
  scalar_t reg_offset;
  logic [`IO_REG_IDX_WIDTH-1:0] reg_idx;
  logic mapped;

  // Window of consecutive word addresses starting at the base
  assign reg_offset = bank_adr - `IO_REG_BASE;
  assign mapped = bank_adr >= `IO_REG_BASE
    && reg_offset < scalar_t'(`IO_NUM_REGS);
  assign reg_idx = reg_offset[`IO_REG_IDX_WIDTH-1:0];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `IO_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (bank_access_en && bank_store && mapped)
      regs[reg_idx] <= bank_write_value;
  end

  // Unmapped reads come back as zero
  assign bank_read_value = mapped ? regs[reg_idx] : '0;

endmodule

`default_nettype wire

// ==== logic/io_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module io_subsystem
  import io_pkg::*;
  (
    input logic clk,
    input logic reset,
    input logic dd_io_write_en,
    input logic dd_io_read_en,
    input local_thread_idx_t dd_io_thread_idx,
    input scalar_t dd_io_adr,
    input scalar_t dd_io_write_value,
    output scalar_t ior_read_value,
    output logic ior_rollback_en,
    output local_thread_bitmap_t ior_pending,
    output local_thread_bitmap_t ior_wake_bitmap
  );

  logic ior_request_valid;
  ioreq_packet_t ior_request;
  logic ii_ready;
  logic ii_response_valid;
  iorsp_packet_t ii_response;
  logic bank_access_en;
  logic bank_store;
  scalar_t bank_adr;
  scalar_t bank_write_value;
  scalar_t bank_read_value;

  io_request_queue i_io_request_queue
  (
    .clk(clk),
    .reset(reset),
    .dd_io_write_en(dd_io_write_en),
    .dd_io_read_en(dd_io_read_en),
    .dd_io_thread_idx(dd_io_thread_idx),
    .dd_io_adr(dd_io_adr),
    .dd_io_write_value(dd_io_write_value),
    .ior_read_value(ior_read_value),
    .ior_rollback_en(ior_rollback_en),
    .ior_pending(ior_pending),
    .ior_wake_bitmap(ior_wake_bitmap),
    .ii_ready(ii_ready),
    .ii_response_valid(ii_response_valid),
    .ii_response(ii_response),
    .ior_request_valid(ior_request_valid),
    .ior_request(ior_request)
  );

  io_interconnect i_io_interconnect
  (
    .clk(clk),
    .reset(reset),
    .ior_request_valid(ior_request_valid),
    .ior_request(ior_request),
    .ii_ready(ii_ready),
    .ii_response_valid(ii_response_valid),
    .ii_response(ii_response),
    .bank_access_en(bank_access_en),
    .bank_store(bank_store),
    .bank_adr(bank_adr),
    .bank_write_value(bank_write_value),
    .bank_read_value(bank_read_value)
  );

  io_register_bank i_io_register_bank
  (
    .clk(clk),
    .reset(reset),
    .bank_access_en(bank_access_en),
    .bank_store(bank_store),
    .bank_adr(bank_adr),
    .bank_write_value(bank_write_value),
    .bank_read_value(bank_read_value)
  );

endmodule

`default_nettype wire

// ==== verif/io_subsystem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_defs.svh"

module io_subsystem_tb
  import io_pkg::*;
  ();

  // About 6x margin over 4 threads x 64 accesses x ~12 cycles
  localparam int CYCLE_LIMIT = 20000;
  localparam int ACCESSES_PER_THREAD = 64;

  typedef enum logic [1:0]
  {
    AGENT_IDLE,
    AGENT_WAIT,
    AGENT_WOKEN
  } agent_state_t;

  typedef struct packed
  {
    logic store;
    scalar_t address;
    scalar_t value;
  } access_t;

  logic clk;
  logic reset;
  logic dd_io_write_en;
  logic dd_io_read_en;
  local_thread_idx_t dd_io_thread_idx;
  scalar_t dd_io_adr;
  scalar_t dd_io_write_value;
  scalar_t ior_read_value;
  logic ior_rollback_en;
  local_thread_bitmap_t ior_pending;
  local_thread_bitmap_t ior_wake_bitmap;

  agent_state_t agent_state[`THREADS_PER_CORE];
  access_t current_access[`THREADS_PER_CORE];
  scalar_t expected_read[`THREADS_PER_CORE];
  access_t work_q[`THREADS_PER_CORE][$];

  // Flags for the last strobe that the next cycle checks
  logic issue_first;
  logic issue_reissue;
  logic reissue_load;
  scalar_t load_expected;
  local_thread_bitmap_t waiting_bitmap;
  local_thread_bitmap_t pending_seen;

  scalar_t model_regs[`IO_NUM_REGS];
  integer seed;
  int error_count;
  int cycle_count;
  string test_name;

  io_subsystem i_io_subsystem
  (
    .clk(clk),
    .reset(reset),
    .dd_io_write_en(dd_io_write_en),
    .dd_io_read_en(dd_io_read_en),
    .dd_io_thread_idx(dd_io_thread_idx),
    .dd_io_adr(dd_io_adr),
    .dd_io_write_value(dd_io_write_value),
    .ior_read_value(ior_read_value),
    .ior_rollback_en(ior_rollback_en),
    .ior_pending(ior_pending),
    .ior_wake_bitmap(ior_wake_bitmap)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  function automatic logic in_window(scalar_t adr);
    return adr >= `IO_REG_BASE && adr < `IO_REG_BASE + `IO_NUM_REGS;
  endfunction

  function automatic logic can_issue(int t);
    return (agent_state[t] == AGENT_IDLE && work_q[t].size() > 0)
      || agent_state[t] == AGENT_WOKEN;
  endfunction

  function automatic logic all_done();
    for (int t = 0; t < `THREADS_PER_CORE; t++)
    begin
      if (agent_state[t] != AGENT_IDLE || work_q[t].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic queue_access(int t, logic store, scalar_t adr, scalar_t value);
    work_q[t].push_back('{store: store, address: adr, value: value});
  endtask

  task automatic drive_access(int t, access_t acc);
    dd_io_thread_idx = local_thread_idx_t'(t);
    dd_io_read_en = !acc.store;
    dd_io_write_en = acc.store;
    dd_io_adr = acc.address;
    dd_io_write_value = acc.value;
  endtask

  // Stores update the model in wake order and loads read it there too
  task automatic take_wake(int t);
    access_t acc;
    int idx;
    acc = current_access[t];
    idx = int'(acc.address - `IO_REG_BASE);
    if (acc.store && in_window(acc.address))
      model_regs[idx] = acc.value;
    else if (!acc.store)
      expected_read[t] = in_window(acc.address) ? model_regs[idx] : '0;
    agent_state[t] = AGENT_WOKEN;
    waiting_bitmap[t] = 1'b0;
  endtask

  // One falling edge of the data cache stage with at most one thread on the port
  task automatic step_cycle();
    int start;
    int t;
    int picked;
    picked = -1;
    issue_first = 1'b0;
    issue_reissue = 1'b0;
    reissue_load = 1'b0;
    dd_io_read_en = 1'b0;
    dd_io_write_en = 1'b0;
    pending_seen = pending_seen | ior_pending;
    start = int'($unsigned($random(seed)) % `THREADS_PER_CORE);
    for (int i = 0; i < `THREADS_PER_CORE; i++)
    begin
      t = (start + i) % `THREADS_PER_CORE;
      if (picked < 0 && can_issue(t))
        picked = t;
    end
    if (picked >= 0 && agent_state[picked] == AGENT_WOKEN)
    begin
      agent_state[picked] = AGENT_IDLE;
      issue_reissue = 1'b1;
      reissue_load = !current_access[picked].store;
      load_expected = expected_read[picked];
      drive_access(picked, current_access[picked]);
    end
    else if (picked >= 0)
    begin
      current_access[picked] = work_q[picked].pop_front();
      agent_state[picked] = AGENT_WAIT;
      waiting_bitmap[picked] = 1'b1;
      pending_seen[picked] = 1'b0;
      issue_first = 1'b1;
      drive_access(picked, current_access[picked]);
    end
    // Wakes after the pick so a re-issue comes a cycle after the response
    for (int w = 0; w < `THREADS_PER_CORE; w++)
    begin
      if (ior_wake_bitmap[w] && agent_state[w] == AGENT_WAIT)
        take_wake(w);
    end
  endtask

  task automatic run_until_done();
    do
    begin
      @(negedge clk);
      step_cycle();
    end
    while (!all_done());
    // One quiet cycle so the last re-issue is checked within this test
    @(negedge clk);
    step_cycle();
    @(posedge clk);
  endtask

  // Mostly mapped registers with some addresses just past the window
  task automatic queue_random_accesses();
    scalar_t adr;
    for (int t = 0; t < `THREADS_PER_CORE; t++)
    begin
      for (int i = 0; i < ACCESSES_PER_THREAD; i++)
      begin
        adr = `IO_REG_BASE + ($unsigned($random(seed)) % `IO_NUM_REGS);
        if ($unsigned($random(seed)) % 8 == 0)
          adr = `IO_REG_BASE + `IO_NUM_REGS + ($unsigned($random(seed)) % 16);
        queue_access(t, 1'($random(seed)), adr, $random(seed));
      end
    end
  endtask

  reset_outputs_clear: assert property (@(negedge clk)
    $fell(reset) |-> !ior_rollback_en && ior_pending == '0 && ior_wake_bitmap == '0)
    else
    begin
      error_count++;
      $display("FAIL %s: expected rollback/pending/wake 0/0/0, actual %b/%b/%b", test_name,
        $sampled(ior_rollback_en), $sampled(ior_pending), $sampled(ior_wake_bitmap));
    end

  rollback_on_first_issue: assert property (@(negedge clk) disable iff (reset)
    issue_first |-> ior_rollback_en)
    else
    begin
      error_count++;
      $display("FAIL %s: expected rollback 1, actual %b", test_name, $sampled(ior_rollback_en));
    end

  no_rollback_on_reissue: assert property (@(negedge clk) disable iff (reset)
    issue_reissue |-> !ior_rollback_en)
    else
    begin
      error_count++;
      $display("FAIL %s: expected rollback 0, actual %b", test_name, $sampled(ior_rollback_en));
    end

  load_value_matches: assert property (@(negedge clk) disable iff (reset)
    reissue_load |-> ior_read_value == load_expected)
    else
    begin
      error_count++;
      $display("FAIL %s: expected read value %h, actual %h", test_name,
        $sampled(load_expected), $sampled(ior_read_value));
    end

  wake_hits_waiting_thread: assert property (@(negedge clk) disable iff (reset)
    |ior_wake_bitmap |-> $onehot(ior_wake_bitmap) && (ior_wake_bitmap & ~waiting_bitmap) == '0)
    else
    begin
      error_count++;
      $display("%s: wake pulse %b is not one thread with an outstanding access",
        test_name, $sampled(ior_wake_bitmap));
    end

  wake_after_pending: assert property (@(negedge clk) disable iff (reset)
    |ior_wake_bitmap |-> (ior_wake_bitmap & ~pending_seen) == '0)
    else
    begin
      error_count++;
      $display("%s: thread woken by %b never showed its pending bit",
        test_name, $sampled(ior_wake_bitmap));
    end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: accesses still outstanding after %0d cycles", CYCLE_LIMIT);
    $display("test failed");
    $finish;
  end

  initial
  begin
    seed = 58381;
    error_count = 0;
    reset = 1'b1;
    dd_io_write_en = 1'b0;
    dd_io_read_en = 1'b0;
    dd_io_thread_idx = '0;
    dd_io_adr = '0;
    dd_io_write_value = '0;
    issue_first = 1'b0;
    issue_reissue = 1'b0;
    reissue_load = 1'b0;
    load_expected = '0;
    waiting_bitmap = '0;
    pending_seen = '0;
    for (int t = 0; t < `THREADS_PER_CORE; t++)
    begin
      agent_state[t] = AGENT_IDLE;
      expected_read[t] = '0;
    end
    for (int r = 0; r < `IO_NUM_REGS; r++)
      model_regs[r] = '0;
    test_name = "reset";
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // Post-reset outputs are checked on the next falling edge
    @(negedge clk);
    @(posedge clk);

    test_name = "round_trip";
    queue_access(0, 1'b0, `IO_REG_BASE, '0);
    queue_access(0, 1'b1, `IO_REG_BASE + 3, 32'hcafe_0003);
    queue_access(0, 1'b0, `IO_REG_BASE + 3, '0);
    queue_access(1, 1'b0, `IO_REG_BASE + 3, '0);
    run_until_done();

    // Fill every register, then try to overwrite from outside the window
    test_name = "unmapped";
    for (int r = 0; r < `IO_NUM_REGS; r++)
      queue_access(2, 1'b1, `IO_REG_BASE + r, ~(`IO_REG_BASE + r) ^ 32'h3c3c_0000);
    queue_access(2, 1'b1, `IO_REG_BASE + `IO_NUM_REGS, 32'hdead_beef);
    queue_access(2, 1'b1, `IO_REG_BASE - 1, 32'hfeed_f00d);
    run_until_done();
    for (int r = 0; r < `IO_NUM_REGS; r++)
      queue_access(3, 1'b0, `IO_REG_BASE + r, '0);
    queue_access(3, 1'b0, `IO_REG_BASE + `IO_NUM_REGS, '0);
    run_until_done();

    test_name = "concurrent";
    queue_random_accesses();
    run_until_done();

    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/io_pkg.sv
logic/rr_arbiter.sv
logic/io_request_queue.sv
logic/io_interconnect.sv
logic/io_register_bank.sv
logic/io_subsystem.sv
verif/io_subsystem_tb.sv
